// File: source/oramCrypt_settings.svh
//------------------------------------------------
// Build-time sizing for the pad generator.
// PAD_SLOTS must be at least 2 and OUT_CREDITS at least 1
//------------------------------------------------
`ifndef ORAMCRYPT_SETTINGS_SVH
`define ORAMCRYPT_SETTINGS_SVH

// Words per block, one cipher lane each
`define CRYPT_LANES 4

// Requests in flight, also the upstream credits after reset
`define PAD_SLOTS 12

// Rounds per encipherment, one per clock
`define CIPHER_ROUNDS 12

// Cipher word width
`define WORD_BITS 64

// Output buffer entries held downstream
`define OUT_CREDITS 2

// Multiplied by the round index in every round
`define ROUND_CONST 64'h9E37_79B9_7F4A_7C15

`endif

// File: source/oramCryptPkg.sv
//------------------------------------------------
// Shared types for the pad generator and mask path.
// Widths come from the settings header
//------------------------------------------------
`include "oramCrypt_settings.svh"

package oramCryptPkg;

    //------------------------------------------------
    // Data words
    //------------------------------------------------

    // One cipher word
    typedef logic [`WORD_BITS-1:0] cryptWord_t;

    // Upstream request
    // iv seeds lane 0, lane j uses iv + j
    typedef struct packed {
        cryptWord_t                     iv;
        cryptWord_t                     key;
        cryptWord_t [`CRYPT_LANES-1:0]  payload;
    } cryptReq_t;

    // Masked block handed downstream
    typedef struct packed {
        cryptWord_t [`CRYPT_LANES-1:0]  payload;
    } cryptResult_t;

    //------------------------------------------------
    // Slot tracking
    //------------------------------------------------

    // Idle -> busy on issue, busy -> ready when all lanes done,
    // ready -> idle when the mask stage takes the pad
    typedef enum logic [1:0] {
        slotIdle,
        slotBusy,
        slotReady
    } slotState_t;

endpackage

// File: source/mixCipher.sv
//------------------------------------------------
// Toy add-rotate-xor lane, not a secure cipher.
// Key must stay stable from load until done
//------------------------------------------------
`timescale 1ns/1ps
`include "oramCrypt_settings.svh"

module mixCipher (
    input  logic                     Clock,
    input  logic                     rst,
    input  logic                     load,
    input  oramCryptPkg::cryptWord_t key,
    input  oramCryptPkg::cryptWord_t block,
    output logic                     done,
    output oramCryptPkg::cryptWord_t pad
);

    localparam int ROUND_BITS = $clog2(`CIPHER_ROUNDS + 1);
    localparam int ROT_BITS   = 13;

    logic [ROUND_BITS-1:0]    round;
    logic                     running;
    oramCryptPkg::cryptWord_t state;
    oramCryptPkg::cryptWord_t summed;
    oramCryptPkg::cryptWord_t mixed;

    //------------------------------------------------
    // Round function
    //------------------------------------------------

    // Add key, rotate left, then xor the scaled round constant
    assign summed = state + key;
    assign mixed  = {summed[`WORD_BITS-ROT_BITS-1:0], summed[`WORD_BITS-1:`WORD_BITS-ROT_BITS]}
                    ^ (oramCryptPkg::cryptWord_t'(round) * `ROUND_CONST);

    //------------------------------------------------
    // Control
    //------------------------------------------------

    // Load restarts the count and drops done
    always_ff @(posedge Clock) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            round   <= '0;
        end else if (load) begin
            running <= 1'b1;
            done    <= 1'b0;
            round   <= '0;
        end else if (running) begin
            round <= round + 1'b1;
            // Last round lands at load edge + CIPHER_ROUNDS
            if (round == ROUND_BITS'(`CIPHER_ROUNDS - 1)) begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    // Whitening on load, one round per cycle after that
    always_ff @(posedge Clock) begin
        if (load) begin
            state <= block ^ key;
        end else if (running) begin
            state <= mixed;
        end
    end

    // Held until the next load
    assign pad = state;

endmodule

// File: source/padBank.sv
//------------------------------------------------
// Round-robin slots of cipher lanes, retired in order.
// Upstream must hold a credit per request sent
//------------------------------------------------
`timescale 1ns/1ps
`include "oramCrypt_settings.svh"

module padBank (
    input  logic                                         Clock,
    input  logic                                         rst,
    input  logic                                         reqValid,
    input  oramCryptPkg::cryptReq_t                      req,
    input  logic                                         padTake,
    output logic                                         padValid,
    output oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  pad,
    output oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  payload,
    output logic                                         reqCredit
);

    localparam int PTR_BITS = $clog2(`PAD_SLOTS);

    logic [PTR_BITS-1:0]                          issuePtr;
    logic [PTR_BITS-1:0]                          retirePtr;
    logic                                         accept;
    oramCryptPkg::slotState_t                     slotState [`PAD_SLOTS];
    oramCryptPkg::slotState_t                     slotNow   [`PAD_SLOTS];
    oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  slotPayload [`PAD_SLOTS];
    oramCryptPkg::cryptWord_t                     slotKey   [`PAD_SLOTS];
    logic [`PAD_SLOTS-1:0]                        laneLoad;
    oramCryptPkg::cryptWord_t                     laneKey   [`PAD_SLOTS];
    logic [`CRYPT_LANES-1:0]                      laneDone  [`PAD_SLOTS];
    oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  lanePad   [`PAD_SLOTS];

    // Pointer step with wrap at the slot count
    function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(`PAD_SLOTS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //------------------------------------------------
    // Issue side
    //------------------------------------------------

    // Credits should keep the issue slot free, check anyway
    assign accept = reqValid && (slotState[issuePtr] == oramCryptPkg::slotIdle);

    always_ff @(posedge Clock) begin
        if (rst) begin
            issuePtr <= '0;
        end else if (accept) begin
            issuePtr <= nextPtr(issuePtr);
        end
    end

    // Payload and key parked with the slot
    always_ff @(posedge Clock) begin
        if (accept) begin
            slotPayload[issuePtr] <= req.payload;
            slotKey[issuePtr]     <= req.key;
        end
    end

    //------------------------------------------------
    // Slot states
    //------------------------------------------------

    // Busy slot counts as ready once every lane reports done
    always_comb begin
        for (int s = 0; s < `PAD_SLOTS; s++) begin
            if (slotState[s] == oramCryptPkg::slotBusy && (&laneDone[s])) begin
                slotNow[s] = oramCryptPkg::slotReady;
            end else begin
                slotNow[s] = slotState[s];
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int s = 0; s < `PAD_SLOTS; s++) begin
                slotState[s] <= oramCryptPkg::slotIdle;
            end
        end else begin
            for (int s = 0; s < `PAD_SLOTS; s++) begin
                if (padTake && retirePtr == PTR_BITS'(s)) begin
                    slotState[s] <= oramCryptPkg::slotIdle;
                end else if (laneLoad[s]) begin
                    slotState[s] <= oramCryptPkg::slotBusy;
                end else begin
                    slotState[s] <= slotNow[s];
                end
            end
        end
    end

    //------------------------------------------------
    // Retire side
    //------------------------------------------------

    always_ff @(posedge Clock) begin
        if (rst) begin
            retirePtr <= '0;
            reqCredit <= 1'b0;
        end else begin
            // Credit goes back the cycle after the slot frees
            reqCredit <= padTake;
            if (padTake) begin
                retirePtr <= nextPtr(retirePtr);
            end
        end
    end

    // Oldest slot only, keeps results in request order
    assign padValid = (slotNow[retirePtr] == oramCryptPkg::slotReady);
    assign pad      = lanePad[retirePtr];
    assign payload  = slotPayload[retirePtr];

    //------------------------------------------------
    // Cipher lanes
    //------------------------------------------------

    for (genvar s = 0; s < `PAD_SLOTS; s++) begin : gSlot
        assign laneLoad[s] = accept && (issuePtr == PTR_BITS'(s));
        // Slot key not latched yet on the load edge
        assign laneKey[s]  = laneLoad[s] ? req.key : slotKey[s];

        for (genvar j = 0; j < `CRYPT_LANES; j++) begin : gLane
            // Lane j counts from iv + j, wraps mod 2^64
            mixCipher u_mixCipher (
                .Clock (Clock),
                .rst   (rst),
                .load  (laneLoad[s]),
                .key   (laneKey[s]),
                .block (req.iv + oramCryptPkg::cryptWord_t'(j)),
                .done  (laneDone[s][j]),
                .pad   (lanePad[s][j])
            );
        end
    end

endmodule

// File: source/maskStage.sv
//------------------------------------------------
// XORs pad into payload, one result per credit.
// Downstream returns one outCredit pulse per entry
//------------------------------------------------
`timescale 1ns/1ps
`include "oramCrypt_settings.svh"

module maskStage (
    input  logic                                         Clock,
    input  logic                                         rst,
    input  logic                                         padValid,
    input  oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  pad,
    input  oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  payload,
    input  logic                                         outCredit,
    output logic                                         padTake,
    output logic                                         outValid,
    output oramCryptPkg::cryptResult_t                   result
);

    localparam int CREDIT_BITS = $clog2(`OUT_CREDITS + 1);

    logic [CREDIT_BITS-1:0]                       outCount;
    logic                                         haveCredit;
    oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  masked;

    //------------------------------------------------
    // Output credits
    //------------------------------------------------

    assign haveCredit = (outCount != '0);

    // Take the oldest pad only with a buffer entry free downstream
    assign padTake = padValid && haveCredit;

    // Return and spend may land in the same cycle
    always_ff @(posedge Clock) begin
        if (rst) begin
            outCount <= CREDIT_BITS'(`OUT_CREDITS);
        end else begin
            case ({outCredit, padTake})
                2'b10:   outCount <= outCount + 1'b1;
                2'b01:   outCount <= outCount - 1'b1;
                default: outCount <= outCount;
            endcase
        end
    end

    //------------------------------------------------
    // Masking
    //------------------------------------------------

    // Word-wise XOR across all lanes
    assign masked = pad ^ payload;

    // Valid one edge after padTake
    always_ff @(posedge Clock) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= padTake;
        end
    end

    // Result only meaningful while outValid is high
    always_ff @(posedge Clock) begin
        if (padTake) begin
            result.payload <= masked;
        end
    end

endmodule

// File: source/oramCryptTop.sv
//------------------------------------------------
// Pad generator plus masking, credit flow both ways.
// Upstream starts with PAD_SLOTS credits
//------------------------------------------------
`timescale 1ns/1ps
`include "oramCrypt_settings.svh"

module oramCryptTop (
    input  logic                        Clock,
    input  logic                        rst,
    input  logic                        reqValid,
    input  oramCryptPkg::cryptReq_t     req,
    output logic                        reqCredit,
    input  logic                        outCredit,
    output logic                        outValid,
    output oramCryptPkg::cryptResult_t  result
);

    // Oldest ready slot handed to the mask stage
    logic                                         padValid;
    logic                                         padTake;
    oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  pad;
    oramCryptPkg::cryptWord_t [`CRYPT_LANES-1:0]  payload;

    padBank u_padBank (
        .Clock     (Clock),
        .rst       (rst),
        .reqValid  (reqValid),
        .req       (req),
        .padTake   (padTake),
        .padValid  (padValid),
        .pad       (pad),
        .payload   (payload),
        .reqCredit (reqCredit)
    );

    maskStage u_maskStage (
        .Clock     (Clock),
        .rst       (rst),
        .padValid  (padValid),
        .pad       (pad),
        .payload   (payload),
        .outCredit (outCredit),
        .padTake   (padTake),
        .outValid  (outValid),
        .result    (result)
    );

endmodule

// File: sim/cipherModel.svh
//------------------------------------------------
// Reference cipher and mask rule, included in the testbench.
// Needs the settings header included first
//------------------------------------------------
`ifndef CIPHERMODEL_SVH
`define CIPHERMODEL_SVH

// Rotate left by 13 over one word
function automatic oramCryptPkg::cryptWord_t rotl13(input oramCryptPkg::cryptWord_t w);
    return (w << 13) | (w >> (`WORD_BITS - 13));
endfunction

// One lane: counter iv + lane, whitened with the key, then the rounds
function automatic oramCryptPkg::cryptWord_t lanePad(
    input oramCryptPkg::cryptWord_t iv,
    input oramCryptPkg::cryptWord_t key,
    input int                       lane
);
    oramCryptPkg::cryptWord_t st;
    // Counter wraps mod 2^64
    st = (iv + oramCryptPkg::cryptWord_t'(lane)) ^ key;
    for (int r = 0; r < `CIPHER_ROUNDS; r++) begin
        st = rotl13(st + key) ^ (oramCryptPkg::cryptWord_t'(r) * `ROUND_CONST);
    end
    return st;
endfunction

// Expected downstream block for one request
function automatic oramCryptPkg::cryptResult_t maskedBlock(input oramCryptPkg::cryptReq_t r);
    oramCryptPkg::cryptResult_t res;
    for (int j = 0; j < `CRYPT_LANES; j++) begin
        res.payload[j] = r.payload[j] ^ lanePad(r.iv, r.key, j);
    end
    return res;
endfunction

`endif

// File: sim/oramCryptTb.sv
//------------------------------------------------
// Directed tests of the pad generator with credit flow.
// Monitor samples on rising edges, stimulus on falling edges
//------------------------------------------------
`timescale 1ns/1ps
`include "oramCrypt_settings.svh"

module oramCryptTb;

    localparam int TOTAL_REQS      = 2 + 2 * `PAD_SLOTS;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * (`CIPHER_ROUNDS + 20) + 400;
    localparam int WAIT_LIMIT      = `PAD_SLOTS * (`CIPHER_ROUNDS + 20);

    logic                       Clock;
    logic                       rst;
    logic                       reqValid;
    oramCryptPkg::cryptReq_t    req;
    logic                       reqCredit;
    logic                       outCredit;
    logic                       outValid;
    oramCryptPkg::cryptResult_t result;

    integer seed = 32'hd127_ef4e;
    logic   autoReturn;

    // Each counter has one writing process
    int cycleCount      = 0;
    int resultCount     = 0;
    int creditsReturned = 0;
    int lastResultCycle = 0;
    int resultChecks    = 0;
    int resultErrors    = 0;
    int requestsSent    = 0;
    int returnsGiven    = 0;
    int wordChecks      = 0;
    int wordErrors      = 0;

    // Model results in request order
    oramCryptPkg::cryptResult_t expQ [$];
    oramCryptPkg::cryptResult_t expHead;

    `include "cipherModel.svh"

    oramCryptTop u_oramCryptTop (
        .Clock     (Clock),
        .rst       (rst),
        .reqValid  (reqValid),
        .req       (req),
        .reqCredit (reqCredit),
        .outCredit (outCredit),
        .outValid  (outValid),
        .result    (result)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    //------------------------------------------------
    // Compare tasks and helpers
    //------------------------------------------------

    task automatic checkResult(input string name, input oramCryptPkg::cryptResult_t got,
                               input oramCryptPkg::cryptResult_t exp);
        resultChecks++;
        if (got !== exp) begin
            resultErrors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input oramCryptPkg::cryptWord_t got,
                             input oramCryptPkg::cryptWord_t exp);
        wordChecks++;
        if (got !== exp) begin
            wordErrors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic flagError(input string msg);
        wordErrors++;
        $display("ERROR %s", msg);
    endtask

    function automatic int errorTotal();
        return resultErrors + wordErrors;
    endfunction

    function automatic oramCryptPkg::cryptWord_t countWord(input int n);
        return oramCryptPkg::cryptWord_t'(n);
    endfunction

    // Upstream credits still in hand
    function automatic int creditsHeld();
        return `PAD_SLOTS + creditsReturned - requestsSent;
    endfunction

    function automatic oramCryptPkg::cryptWord_t randomWord();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic oramCryptPkg::cryptReq_t randomReq();
        oramCryptPkg::cryptReq_t r;
        r.iv  = randomWord();
        r.key = randomWord();
        for (int j = 0; j < `CRYPT_LANES; j++) begin
            r.payload[j] = randomWord();
        end
        return r;
    endfunction

    //------------------------------------------------
    // Monitor, credit returner, watchdog
    //------------------------------------------------

    // Registered outputs read as they stood before the edge
    initial begin
        forever begin
            @(posedge Clock);
            cycleCount++;
            if (!rst && reqCredit) begin
                creditsReturned++;
                if (creditsReturned > requestsSent) begin
                    resultErrors++;
                    $display("ERROR more request credits came back than requests were sent");
                end
            end
            if (!rst && outValid) begin
                resultCount++;
                lastResultCycle = cycleCount;
                if (resultCount - returnsGiven > `OUT_CREDITS) begin
                    resultErrors++;
                    $display("ERROR result sent with no free output buffer entry");
                end
                if (expQ.size() == 0) begin
                    resultErrors++;
                    $display("ERROR result arrived with no request outstanding");
                end else begin
                    expHead = expQ.pop_front();
                    checkResult("result", result, expHead);
                end
            end
        end
    end

    // Downstream frees one entry per cycle while enabled
    initial begin
        outCredit = 1'b0;
        forever begin
            @(negedge Clock);
            if (autoReturn && (resultCount > returnsGiven)) begin
                outCredit = 1'b1;
                returnsGiven++;
            end else begin
                outCredit = 1'b0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clock);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    //------------------------------------------------
    // Stimulus
    //------------------------------------------------

    // Sends on the next falling edge that finds a credit
    task automatic sendRequest(input oramCryptPkg::cryptReq_t r);
        int waited;
        waited = 0;
        @(negedge Clock);
        while (creditsHeld() == 0) begin
            reqValid = 1'b0;
            if (waited == WAIT_LIMIT) begin
                flagError("no request credit came back in time");
                return;
            end
            waited++;
            @(negedge Clock);
        end
        reqValid = 1'b1;
        req      = r;
        requestsSent++;
        expQ.push_back(maskedBlock(r));
    endtask

    task automatic releaseRequest();
        @(negedge Clock);
        reqValid = 1'b0;
    endtask

    task automatic waitForResults(input int target);
        int waited;
        waited = 0;
        while (resultCount < target) begin
            if (waited == WAIT_LIMIT) begin
                flagError("expected results did not arrive in time");
                return;
            end
            waited++;
            @(negedge Clock);
        end
    endtask

    // All results out, all credits back on both sides
    task automatic waitIdle();
        int waited;
        waited = 0;
        while (expQ.size() != 0 || creditsHeld() != `PAD_SLOTS
               || resultCount != returnsGiven) begin
            if (waited == WAIT_LIMIT) begin
                flagError("design did not return to idle");
                return;
            end
            waited++;
            @(negedge Clock);
        end
        repeat (2) @(negedge Clock);
    endtask

    task automatic finishTest(input string name, input int startErrors);
        int errs;
        errs = errorTotal() - startErrors;
        if (errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d error(s)", name, errs);
        end
    endtask

    //------------------------------------------------
    // Directed tests
    //------------------------------------------------

    task automatic idleAfterReset();
        int startErrors;
        startErrors = errorTotal();
        repeat (20) begin
            @(negedge Clock);
            if (outValid || reqCredit) begin
                flagError("outValid or reqCredit high with no request sent");
            end
        end
        checkWord("result count", countWord(resultCount), '0);
        checkWord("reqCredit pulses", countWord(creditsReturned), '0);
        finishTest("idle after reset", startErrors);
    endtask

    task automatic singleRequest();
        int startErrors;
        int sendCycle;
        int startResults;
        startErrors  = errorTotal();
        startResults = resultCount;
        sendRequest(randomReq());
        sendCycle = cycleCount;
        releaseRequest();
        waitForResults(startResults + 1);
        // Accept edge follows the send and the monitor sees outValid one edge late
        if (lastResultCycle - sendCycle - 2 < `CIPHER_ROUNDS + 1) begin
            flagError("result came sooner than the cipher rounds allow");
        end
        waitIdle();
        finishTest("single request", startErrors);
    endtask

    // Lanes 1 to 3 see counters 0, 1 and 2
    task automatic counterWrap();
        int                      startErrors;
        oramCryptPkg::cryptReq_t r;
        startErrors = errorTotal();
        r       = randomReq();
        r.iv    = '1;
        r.key   = '0;
        sendRequest(r);
        releaseRequest();
        waitIdle();
        finishTest("counter wraparound", startErrors);
    endtask

    task automatic backToBack();
        int startErrors;
        int startResults;
        startErrors  = errorTotal();
        startResults = resultCount;
        for (int i = 0; i < `PAD_SLOTS; i++) begin
            sendRequest(randomReq());
        end
        releaseRequest();
        waitForResults(startResults + `PAD_SLOTS);
        waitIdle();
        checkWord("results", countWord(resultCount - startResults), countWord(`PAD_SLOTS));
        finishTest("back to back", startErrors);
    endtask

    task automatic outputBackPressure();
        int startErrors;
        int startResults;
        int startCredits;
        startErrors  = errorTotal();
        startResults = resultCount;
        startCredits = creditsReturned;
        autoReturn   = 1'b0;
        for (int i = 0; i < `PAD_SLOTS; i++) begin
            sendRequest(randomReq());
        end
        releaseRequest();
        // Long enough for every slot to finish its rounds
        repeat (`CIPHER_ROUNDS + 30) @(negedge Clock);
        checkWord("results while stalled", countWord(resultCount - startResults),
                  countWord(`OUT_CREDITS));
        checkWord("reqCredit pulses while stalled",
                  countWord(creditsReturned - startCredits), countWord(`OUT_CREDITS));
        checkWord("upstream credits while stalled", countWord(creditsHeld()),
                  countWord(`OUT_CREDITS));
        autoReturn = 1'b1;
        waitForResults(startResults + `PAD_SLOTS);
        waitIdle();
        checkWord("results after drain", countWord(resultCount - startResults),
                  countWord(`PAD_SLOTS));
        checkWord("reqCredit pulses after drain", countWord(creditsReturned - startCredits),
                  countWord(`PAD_SLOTS));
        finishTest("output back-pressure", startErrors);
    endtask

    initial begin
        rst        = 1'b1;
        reqValid   = 1'b0;
        req        = '0;
        autoReturn = 1'b1;
        repeat (8) @(negedge Clock);
        rst = 1'b0;
        idleAfterReset();
        singleRequest();
        counterWrap();
        backToBack();
        outputBackPressure();
        checkWord("results left over", countWord(expQ.size()), '0);
        $display("Checks: %0d, errors: %0d", resultChecks + wordChecks, errorTotal());
        if (errorTotal() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+source
+incdir+sim
source/oramCryptPkg.sv
source/mixCipher.sv
source/padBank.sv
source/maskStage.sv
source/oramCryptTop.sv
sim/oramCryptTb.sv

// File: Makefile
# Verilator build and run of the pad generator testbench

VERILATOR ?= verilator
TOP       ?= oramCryptTb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
FILELIST  ?= build.f
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv sim/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
